//--- Bender.yml
package:
  name: dmni

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/noc_pkg.sv
      - hdl/dmni_pkg.sv
      - hdl/dmni_apb_regs.sv
      - hdl/hermes_receive.sv
      - hdl/hermes_send.sv
      - hdl/dmni_mem_arbiter.sv
      - hdl/dmni_top.sv
  - target: test
    include_dirs:
      - hdl
      - verif
    files:
      - verif/tb_dmni.sv

//--- dmni.f
+incdir+hdl
+incdir+verif
hdl/noc_pkg.sv
hdl/dmni_pkg.sv
hdl/dmni_apb_regs.sv
hdl/hermes_receive.sv
hdl/hermes_send.sv
hdl/dmni_mem_arbiter.sv
hdl/dmni_top.sv
verif/tb_dmni.sv

//--- hdl/dmni_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmni_defs.svh"

module dmni_apb_regs (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  logic [`DMNI_APB_AW-1:0] paddr_i,
    input  logic [31:0]             pwdata_i,
    output logic [31:0]             prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    input  dmni_pkg::dmni_status_t  status_i,
    input  noc_pkg::flit_t          flits_i,
    output dmni_pkg::dmni_cfg_t     cfg_o,
    output dmni_pkg::dmni_cmd_t     cmd_o
);

    logic                access;
    logic                wr_en;
    logic                mapped;
    dmni_pkg::dmni_cfg_t cfg_q;
    dmni_pkg::dmni_cmd_t cmd_q;

    assign access = psel_i && penable_i;
    assign wr_en  = access && pwrite_i;

    // =========================================================================
    // read mux and offset decode
    // =========================================================================

    always_comb begin
        mapped   = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            `DMNI_REG_SIZE:   prdata_o = cfg_q.size;
            `DMNI_REG_SIZE2:  prdata_o = cfg_q.size2;
            `DMNI_REG_ADDR:   prdata_o = cfg_q.addr;
            `DMNI_REG_ADDR2:  prdata_o = cfg_q.addr2;
            `DMNI_REG_START:  prdata_o = '0;          // write only
            `DMNI_REG_STATUS: prdata_o = {{(32 - $bits(status_i)){1'b0}}, status_i};
            `DMNI_REG_FLITS:  prdata_o = flits_i;
            default:          mapped   = 1'b0;
        endcase
    end

    assign pready_o  = 1'b1;                      // no wait states
    assign pslverr_o = access && !mapped;

    // =========================================================================
    // configuration registers
    // =========================================================================

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cfg_q <= '0;
        end else if (wr_en) begin
            case (paddr_i)
                `DMNI_REG_SIZE:  cfg_q.size  <= pwdata_i;
                `DMNI_REG_SIZE2: cfg_q.size2 <= pwdata_i;
                `DMNI_REG_ADDR:  cfg_q.addr  <= pwdata_i;
                `DMNI_REG_ADDR2: cfg_q.addr2 <= pwdata_i;
                default: ;
            endcase
        end
    end

    // start pulse, seen by the engines one cycle after the access
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cmd_q <= '0;
        end else begin
            cmd_q.start <= wr_en && (paddr_i == `DMNI_REG_START);
            if (wr_en && (paddr_i == `DMNI_REG_START)) begin
                cmd_q.op <= dmni_pkg::dmni_op_t'(pwdata_i[0]);
            end
        end
    end

    assign cfg_o = cfg_q;
    assign cmd_o = cmd_q;

    start_single_cycle: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        cmd_q.start |=> !cmd_q.start
    ) else $error("start pulse held for two cycles");

endmodule

`default_nettype wire

//--- hdl/dmni_defs.svh
`ifndef DMNI_DEFS_SVH
`define DMNI_DEFS_SVH

// widths
`define DMNI_FLIT_W      32
`define DMNI_ADDR_W      32
`define DMNI_APB_AW      8
`define DMNI_WORD_BYTES  4      // address step and byte enables per word

// memory port time slice, in cycles
`define DMNI_ARB_SLICE   15

// APB register map (byte offsets)
`define DMNI_REG_SIZE    8'h00
`define DMNI_REG_SIZE2   8'h04
`define DMNI_REG_ADDR    8'h08
`define DMNI_REG_ADDR2   8'h0C
`define DMNI_REG_START   8'h10
`define DMNI_REG_STATUS  8'h14
`define DMNI_REG_FLITS   8'h18

`endif

//--- hdl/dmni_mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmni_defs.svh"

module dmni_mem_arbiter (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  dmni_pkg::eng_req_t send_req_i,
    input  dmni_pkg::eng_req_t recv_req_i,
    output logic               send_grant_o,
    output logic               recv_grant_o,
    output noc_pkg::mem_req_t  mem_o
);

    localparam int TIMER_W = $clog2(`DMNI_ARB_SLICE + 1);

    dmni_pkg::mem_src_t owner_q;
    dmni_pkg::mem_src_t other;
    logic [TIMER_W-1:0] timer_q;
    logic               own_pend;
    logic               other_pend;
    logic               rotate;

    // =========================================================================
    // grant rotation
    // =========================================================================

    always_comb begin
        if (owner_q == dmni_pkg::SRC_SEND) begin
            other      = dmni_pkg::SRC_RECEIVE;
            own_pend   = send_req_i.pending;
            other_pend = recv_req_i.pending;
        end else begin
            other      = dmni_pkg::SRC_SEND;
            own_pend   = recv_req_i.pending;
            other_pend = send_req_i.pending;
        end
    end

    assign rotate = other_pend && (timer_q == '0 || !own_pend);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            owner_q <= dmni_pkg::SRC_SEND;
            timer_q <= '0;
        end else if (rotate) begin
            owner_q <= other;
            timer_q <= TIMER_W'(`DMNI_ARB_SLICE);   // fresh slice
        end else if (timer_q != '0) begin
            timer_q <= timer_q - 1'b1;
        end
    end

    assign send_grant_o = (owner_q == dmni_pkg::SRC_SEND);
    assign recv_grant_o = (owner_q == dmni_pkg::SRC_RECEIVE);

    // =========================================================================
    // memory port
    // =========================================================================

    assign mem_o.addr  = recv_grant_o ? recv_req_i.addr : send_req_i.addr;
    assign mem_o.wdata = recv_grant_o ? recv_req_i.wdata : send_req_i.wdata;
    assign mem_o.we    = {`DMNI_WORD_BYTES{recv_grant_o && recv_req_i.pending}};

    // a pending receive engine gets the port within one slice
    recv_not_starved: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (recv_req_i.pending && !recv_grant_o)
            |-> ##[1:`DMNI_ARB_SLICE + 1] (recv_grant_o || !recv_req_i.pending)
    ) else $error("receive engine waited longer than a slice for the port");

endmodule

`default_nettype wire

//--- hdl/dmni_pkg.sv
`default_nettype none

`include "dmni_defs.svh"

package dmni_pkg;

    typedef enum logic {
        OP_SEND    = 1'b0,
        OP_RECEIVE = 1'b1
    } dmni_op_t;

    // software programmed transfer
    typedef struct packed {
        noc_pkg::flit_t          size;
        noc_pkg::flit_t          size2;
        logic [`DMNI_ADDR_W-1:0] addr;
        logic [`DMNI_ADDR_W-1:0] addr2;
    } dmni_cfg_t;

    typedef struct packed {
        logic     start;             // one cycle pulse
        dmni_op_t op;
    } dmni_cmd_t;

    // STATUS register, bit 2 down to bit 0
    typedef struct packed {
        logic send_active;
        logic receive_active;
        logic receive_available;
    } dmni_status_t;

    typedef enum logic {
        SRC_SEND    = 1'b0,
        SRC_RECEIVE = 1'b1
    } mem_src_t;

    // engine to arbiter
    typedef struct packed {
        logic                    pending;
        logic [`DMNI_ADDR_W-1:0] addr;
        noc_pkg::flit_t          wdata;
    } eng_req_t;

endpackage

`default_nettype wire

//--- hdl/dmni_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmni_defs.svh"

module dmni_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // APB
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  logic [`DMNI_APB_AW-1:0] paddr_i,
    input  logic [31:0]             pwdata_i,
    output logic [31:0]             prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    // Hermes
    input  noc_pkg::hermes_in_t     noc_i,
    output logic                    noc_credit_o,
    output noc_pkg::hermes_out_t    noc_o,
    input  logic                    noc_ack_i,
    // memory
    output noc_pkg::mem_req_t       mem_o,
    input  noc_pkg::flit_t          mem_rdata_i
);

    dmni_pkg::dmni_cfg_t    cfg;
    dmni_pkg::dmni_cmd_t    cmd;
    dmni_pkg::dmni_status_t status;
    noc_pkg::flit_t         flits;
    dmni_pkg::eng_req_t     send_req;
    dmni_pkg::eng_req_t     recv_req;
    logic                   send_grant;
    logic                   recv_grant;

    dmni_apb_regs u_regs (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .status_i  (status),
        .flits_i   (flits),
        .cfg_o     (cfg),
        .cmd_o     (cmd)
    );

    hermes_receive u_receive (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .link_i      (noc_i),
        .credit_o    (noc_credit_o),
        .cfg_i       (cfg),
        .cmd_i       (cmd),
        .grant_i     (recv_grant),
        .req_o       (recv_req),
        .active_o    (status.receive_active),
        .available_o (status.receive_available),
        .flits_o     (flits)
    );

    hermes_send u_send (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .link_o      (noc_o),
        .ack_i       (noc_ack_i),
        .mem_rdata_i (mem_rdata_i),
        .cfg_i       (cfg),
        .cmd_i       (cmd),
        .grant_i     (send_grant),
        .req_o       (send_req),
        .active_o    (status.send_active)
    );

    dmni_mem_arbiter u_arbiter (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .send_req_i   (send_req),
        .recv_req_i   (recv_req),
        .send_grant_o (send_grant),
        .recv_grant_o (recv_grant),
        .mem_o        (mem_o)
    );

endmodule

`default_nettype wire

//--- hdl/hermes_receive.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmni_defs.svh"

module hermes_receive (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  noc_pkg::hermes_in_t   link_i,
    output logic                  credit_o,
    input  dmni_pkg::dmni_cfg_t   cfg_i,
    input  dmni_pkg::dmni_cmd_t   cmd_i,
    input  logic                  grant_i,
    output dmni_pkg::eng_req_t    req_o,
    output logic                  active_o,
    output logic                  available_o,
    output noc_pkg::flit_t        flits_o
);

    typedef enum logic [3:0] {
        RX_HEADER = 4'b0001,
        RX_SIZE   = 4'b0010,
        RX_WAIT   = 4'b0100,
        RX_DATA   = 4'b1000
    } rx_state_t;

    rx_state_t               state_q;
    rx_state_t               state_d;
    logic                    take_data;
    logic                    start_rx;
    noc_pkg::flit_t          payload_q;   // flits left in the packet
    noc_pkg::flit_t          size_q;      // words left in this portion
    logic [`DMNI_ADDR_W-1:0] addr_q;

    assign take_data = (state_q == RX_DATA) && link_i.rx && grant_i;
    assign start_rx  = cmd_i.start && (cmd_i.op == dmni_pkg::OP_RECEIVE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            RX_HEADER: if (link_i.rx) state_d = RX_SIZE;
            RX_SIZE:   if (link_i.rx) state_d = RX_WAIT;
            RX_WAIT:   if (start_rx) state_d = RX_DATA;
            RX_DATA: begin
                if (take_data) begin
                    if (payload_q == 'd1) begin
                        state_d = RX_HEADER;       // packet done
                    end else if (size_q == 'd1) begin
                        state_d = RX_WAIT;         // portion done, rest stays in link
                    end
                end
            end
            default:   state_d = RX_HEADER;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= RX_HEADER;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            payload_q <= '0;
            size_q    <= '0;
            addr_q    <= '0;
        end else begin
            if (state_q == RX_SIZE && link_i.rx) begin
                payload_q <= link_i.data;
            end else if (take_data) begin
                payload_q <= payload_q - 1'b1;
            end
            if (state_q == RX_WAIT && start_rx) begin
                addr_q <= cfg_i.addr;
                size_q <= cfg_i.size;
            end else if (take_data) begin
                addr_q <= addr_q + `DMNI_ADDR_W'(`DMNI_WORD_BYTES);
                size_q <= size_q - 1'b1;
            end
        end
    end

    always_comb begin
        case (state_q)
            RX_WAIT: credit_o = 1'b0;
            RX_DATA: credit_o = link_i.rx && grant_i;
            default: credit_o = 1'b1;           // header and size
        endcase
    end

    assign req_o.pending = (state_q == RX_DATA) && link_i.rx;
    assign req_o.addr    = addr_q;
    assign req_o.wdata   = link_i.data;

    assign active_o    = (state_q == RX_DATA);
    assign available_o = (state_q == RX_WAIT);
    assign flits_o     = payload_q;

    // every flit taken after the size flit uses up one payload word
    flit_counted: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (link_i.rx && credit_o && (state_q == RX_WAIT || state_q == RX_DATA))
            |=> (payload_q == $past(payload_q) - 1'b1)
    ) else $error("flit accepted without being counted");

endmodule

`default_nettype wire

//--- hdl/hermes_send.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmni_defs.svh"

module hermes_send (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    output noc_pkg::hermes_out_t link_o,
    input  logic                 ack_i,
    input  noc_pkg::flit_t       mem_rdata_i,
    input  dmni_pkg::dmni_cfg_t  cfg_i,
    input  dmni_pkg::dmni_cmd_t  cmd_i,
    input  logic                 grant_i,
    output dmni_pkg::eng_req_t   req_o,
    output logic                 active_o
);

    typedef enum logic [1:0] {
        TX_IDLE = 2'b01,
        TX_DATA = 2'b10
    } tx_state_t;

    tx_state_t               state_q;
    logic                    start_tx;
    logic                    take;
    logic                    last;
    noc_pkg::flit_t          size_q;
    noc_pkg::flit_t          size2_q;
    logic [`DMNI_ADDR_W-1:0] addr_q;
    logic [`DMNI_ADDR_W-1:0] addr2_q;

    // empty transfers are ignored
    assign start_tx = cmd_i.start && (cmd_i.op == dmni_pkg::OP_SEND)
                      && (cfg_i.size != '0 || cfg_i.size2 != '0);
    assign take     = (state_q == TX_DATA) && ack_i && grant_i;
    assign last     = (size_q == 'd1 && size2_q == '0) || (size_q == '0 && size2_q == 'd1);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= TX_IDLE;
        end else begin
            case (state_q)
                TX_IDLE: if (start_tx) state_q <= TX_DATA;
                TX_DATA: if (take && last) state_q <= TX_IDLE;
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            size_q  <= '0;
            size2_q <= '0;
            addr_q  <= '0;
            addr2_q <= '0;
        end else if (state_q == TX_IDLE && start_tx) begin
            size_q  <= cfg_i.size;
            size2_q <= cfg_i.size2;
            addr_q  <= cfg_i.addr;
            addr2_q <= cfg_i.addr2;
        end else if (take) begin
            if (size_q != '0) begin
                size_q <= size_q - 1'b1;
                addr_q <= addr_q + `DMNI_ADDR_W'(`DMNI_WORD_BYTES);
            end else begin
                size2_q <= size2_q - 1'b1;   // second buffer
                addr2_q <= addr2_q + `DMNI_ADDR_W'(`DMNI_WORD_BYTES);
            end
        end
    end

    assign req_o.pending = (state_q == TX_DATA);
    assign req_o.addr    = (size_q != '0) ? addr_q : addr2_q;
    assign req_o.wdata   = '0;              // read only

    assign link_o.tx   = (state_q == TX_DATA);
    assign link_o.data = mem_rdata_i;       // same cycle as the read
    assign active_o    = (state_q == TX_DATA);

    tx_has_words: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        link_o.tx |-> (size_q != '0 || size2_q != '0)
    ) else $error("tx high with both buffers empty");

endmodule

`default_nettype wire

//--- hdl/noc_pkg.sv
`default_nettype none

`include "dmni_defs.svh"

package noc_pkg;

    typedef logic [`DMNI_FLIT_W-1:0] flit_t;

    // Hermes link, receive side
    typedef struct packed {
        logic  rx;
        flit_t data;
    } hermes_in_t;

    // Hermes link, send side
    typedef struct packed {
        logic  tx;
        flit_t data;
    } hermes_out_t;

    // local memory port request
    typedef struct packed {
        logic [`DMNI_WORD_BYTES-1:0] we;
        logic [`DMNI_ADDR_W-1:0]     addr;
        flit_t                       wdata;
    } mem_req_t;

endpackage

`default_nettype wire

//--- verif/tb_dmni_tasks.svh
`ifndef TB_DMNI_TASKS_SVH
`define TB_DMNI_TASKS_SVH

// ============================================================================
// compare tasks
// ============================================================================

task automatic check_flit(input noc_pkg::flit_t exp, input noc_pkg::flit_t got,
                          input string what);
    if (got !== exp) begin
        mismatches++;
        $display("Mismatch at %0t: %s, expected %h, got %h", $time, what, exp, got);
    end
endtask

task automatic check_word(input noc_pkg::flit_t exp, input noc_pkg::flit_t got,
                          input string what);
    if (got !== exp) begin
        mismatches++;
        $display("Mismatch at %0t: memory %s, expected %h, got %h", $time, what, exp, got);
    end
endtask

task automatic check_status(input dmni_pkg::dmni_status_t exp,
                            input dmni_pkg::dmni_status_t got, input string what);
    if (got !== exp) begin
        mismatches++;
        $display("Mismatch at %0t: %s, expected %b, got %b", $time, what, exp, got);
    end
endtask

task automatic check_bit(input logic exp, input logic got, input string what);
    if (got !== exp) begin
        mismatches++;
        $display("Mismatch at %0t: %s, expected %b, got %b", $time, what, exp, got);
    end
endtask

// ============================================================================
// stimulus helpers
// ============================================================================

function automatic noc_pkg::flit_t fill_value(input int idx);
    return (idx * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
endfunction

function automatic noc_pkg::flit_t payload_value(input int tag, input int idx);
    return 32'hD000_0000 | (tag << 16) | idx;
endfunction

// setup, access, then sample once the access edge has passed
task automatic bus_access(input logic write, input logic [`DMNI_APB_AW-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    @(negedge clk_i);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk_i);
    penable = 1'b1;
    @(negedge clk_i);
    rdata   = prdata;
    err     = pslverr;
    check_bit(1'b1, pready, "pready in access phase");
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic write_reg(input logic [`DMNI_APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, addr, data, rdata, err);
    check_bit(1'b0, err, $sformatf("pslverr on write to %h", addr));
endtask

task automatic read_reg(input logic [`DMNI_APB_AW-1:0] addr, output logic [31:0] rdata);
    logic err;
    bus_access(1'b0, addr, '0, rdata, err);
    check_bit(1'b0, err, $sformatf("pslverr on read of %h", addr));
endtask

task automatic start_send(input int a1, input int s1, input int a2, input int s2);
    write_reg(`DMNI_REG_SIZE, s1);
    write_reg(`DMNI_REG_SIZE2, s2);
    write_reg(`DMNI_REG_ADDR, a1);
    write_reg(`DMNI_REG_ADDR2, a2);
    write_reg(`DMNI_REG_START, 32'(dmni_pkg::OP_SEND));
endtask

task automatic start_receive(input int addr, input int size);
    write_reg(`DMNI_REG_SIZE, size);
    write_reg(`DMNI_REG_ADDR, addr);
    write_reg(`DMNI_REG_START, 32'(dmni_pkg::OP_RECEIVE));
endtask

task automatic wait_idle(input string what);
    logic [31:0]            rdata;
    dmni_pkg::dmni_status_t st;
    int                     n;
    n = 0;
    read_reg(`DMNI_REG_STATUS, rdata);
    st = rdata[2:0];
    while (st != '0 && n < TIMEOUT) begin
        read_reg(`DMNI_REG_STATUS, rdata);
        st = rdata[2:0];
        n++;
    end
    if (st != '0) begin
        timeouts++;
        $display("Timed out at %0t waiting for the %s transfer to finish", $time, what);
    end
endtask

// waits for the receive engine to ask software
task automatic wait_available();
    logic [31:0]            rdata;
    dmni_pkg::dmni_status_t st;
    logic                   seen;
    int                     n;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < TIMEOUT) begin
        read_reg(`DMNI_REG_STATUS, rdata);
        st   = rdata[2:0];
        seen = st.receive_available;
        n++;
    end
    if (!seen) begin
        timeouts++;
        $display("Timed out at %0t waiting for the receive engine to report a packet",
                 $time);
    end
endtask

task automatic wait_flits(input int count);
    int n;
    n = 0;
    while (sink_q.size() < count && n < TIMEOUT) begin
        @(negedge clk_i);
        n++;
    end
    if (sink_q.size() < count) begin
        timeouts++;
        $display("Timed out at %0t with %0d of %0d flits sent", $time, sink_q.size(), count);
    end
endtask

task automatic send_flit(input noc_pkg::flit_t data);
    logic [31:0] rnd;
    int          n;
    n = 0;
    if (rx_stalls) begin
        rnd = $random(seed);
        repeat (rnd[1:0]) begin
            @(negedge clk_i);
            noc_in.rx = 1'b0;               // idle gap
        end
    end
    @(negedge clk_i);
    noc_in.rx   = 1'b1;
    noc_in.data = data;
    @(posedge clk_i);
    while (!noc_credit && n < TIMEOUT) begin
        @(posedge clk_i);
        n++;
    end
    if (!noc_credit) begin
        timeouts++;
        $display("Timed out at %0t waiting for credit on flit %h", $time, data);
    end
endtask

task automatic send_packet(input noc_pkg::flit_t header, input noc_pkg::flit_t payload[$]);
    send_flit(header);
    send_flit(payload.size());
    foreach (payload[i]) begin
        send_flit(payload[i]);
    end
    @(negedge clk_i);
    noc_in.rx = 1'b0;
endtask

task automatic check_send_stream(input int a1, input int s1, input int a2, input int s2);
    noc_pkg::flit_t exp [$];
    for (int i = 0; i < s1; i++) begin
        exp.push_back(fill_value(a1 / 4 + i));
    end
    for (int i = 0; i < s2; i++) begin
        exp.push_back(fill_value(a2 / 4 + i));
    end
    check_flit(exp.size(), sink_q.size(), "number of flits sent");
    for (int i = 0; i < exp.size() && i < sink_q.size(); i++) begin
        check_flit(exp[i], sink_q[i], $sformatf("sent flit %0d", i));
    end
endtask

task automatic check_memory(input int base, input noc_pkg::flit_t payload[$],
                            input int first, input int count);
    for (int i = 0; i < count; i++) begin
        check_word(payload[first + i], mem[base / 4 + i],
                   $sformatf("word %0d at %h", i, base + 4 * i));
    end
endtask

// ============================================================================
// directed tests
// ============================================================================

task automatic registers_readback();
    logic [31:0] rdata;
    logic        err;
    read_reg(`DMNI_REG_STATUS, rdata);
    check_status('0, rdata[2:0], "STATUS after reset");
    write_reg(`DMNI_REG_SIZE, 32'h0000_0011);
    write_reg(`DMNI_REG_ADDR, 32'h0000_1234);
    write_reg(`DMNI_REG_SIZE2, 32'h0000_0022);
    write_reg(`DMNI_REG_ADDR2, 32'h8000_00A0);
    read_reg(`DMNI_REG_SIZE, rdata);
    check_flit(32'h0000_0011, rdata, "SIZE readback");
    read_reg(`DMNI_REG_ADDR, rdata);
    check_flit(32'h0000_1234, rdata, "ADDR readback");
    read_reg(`DMNI_REG_SIZE2, rdata);
    check_flit(32'h0000_0022, rdata, "SIZE2 readback");
    read_reg(`DMNI_REG_ADDR2, rdata);
    check_flit(32'h8000_00A0, rdata, "ADDR2 readback");
    bus_access(1'b0, 8'h20, '0, rdata, err);
    check_bit(1'b1, err, "pslverr on unmapped read");
    bus_access(1'b1, 8'h3C, 32'hFFFF_FFFF, rdata, err);
    check_bit(1'b1, err, "pslverr on unmapped write");
endtask

task automatic send_two_buffers();
    sink_q.delete();
    start_send(32'h040, 4, 32'h100, 3);
    wait_flits(7);
    wait_idle("send");
    check_send_stream(32'h040, 4, 32'h100, 3);
endtask

task automatic send_backpressure();
    sink_q.delete();
    ack_random = 1'b1;
    start_send(32'h040, 4, 32'h100, 3);
    wait_flits(7);
    wait_idle("stalled send");
    ack_random = 1'b0;
    check_send_stream(32'h040, 4, 32'h100, 3);
endtask

task automatic receive_whole_packet();
    noc_pkg::flit_t payload [$];
    logic [31:0]    rdata;
    for (int i = 0; i < 5; i++) begin
        payload.push_back(payload_value(4, i));
    end
    fork
        send_packet(32'h0000_0104, payload);
        begin
            wait_available();
            read_reg(`DMNI_REG_FLITS, rdata);
            check_flit(5, rdata, "FLITS after size flit");
            start_receive(32'h200, 5);
        end
    join
    wait_idle("receive");
    check_bit(1'b1, noc_credit, "credit back in header state");
    check_memory(32'h200, payload, 0, 5);
endtask

task automatic receive_partial();
    noc_pkg::flit_t payload [$];
    logic [31:0]    rdata;
    for (int i = 0; i < 6; i++) begin
        payload.push_back(payload_value(5, i));
    end
    fork
        send_packet(32'h0000_0105, payload);
        begin
            wait_available();
            start_receive(32'h280, 2);
            wait_available();
            read_reg(`DMNI_REG_STATUS, rdata);
            check_status(3'b001, rdata[2:0], "STATUS after first portion");
            read_reg(`DMNI_REG_FLITS, rdata);
            check_flit(4, rdata, "FLITS after first portion");
            start_receive(32'h300, 4);
        end
    join
    wait_idle("partial receive");
    check_memory(32'h280, payload, 0, 2);
    check_memory(32'h300, payload, 2, 4);
endtask

task automatic send_and_receive();
    noc_pkg::flit_t payload [$];
    for (int i = 0; i < 24; i++) begin
        payload.push_back(payload_value(6, i));
    end
    sink_q.delete();
    rx_stalls  = 1'b1;
    ack_random = 1'b1;
    fork
        send_packet(32'h0000_0106, payload);
        begin
            wait_available();
            start_receive(32'h340, 24);
            start_send(32'h000, 12, 32'h0C0, 10);
            wait_flits(22);
        end
    join
    wait_idle("concurrent");
    rx_stalls  = 1'b0;
    ack_random = 1'b0;
    check_send_stream(32'h000, 12, 32'h0C0, 10);
    check_memory(32'h340, payload, 0, 24);
endtask

`endif

//--- verif/tb_dmni.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmni_defs.svh"

module tb_dmni;

    localparam int HALF_PERIOD = 50;
    localparam int MEM_WORDS   = 256;
    localparam int TIMEOUT     = 1000;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`DMNI_APB_AW-1:0] paddr;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;
    noc_pkg::hermes_in_t     noc_in;
    logic                    noc_credit;
    noc_pkg::hermes_out_t    noc_out;
    logic                    noc_ack;
    noc_pkg::mem_req_t       mem_req;
    noc_pkg::flit_t          mem_rdata;

    noc_pkg::flit_t          mem [0:MEM_WORDS-1];
    noc_pkg::flit_t          sink_q [$];
    int                      mismatches;
    int                      timeouts;
    integer                  seed;
    logic [31:0]             ack_rnd;
    logic                    ack_random;
    logic                    rx_stalls;

    initial clk_i = 1'b0;
    always #(HALF_PERIOD) clk_i = ~clk_i;

    dmni_top dut0 (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .paddr_i      (paddr),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata),
        .pready_o     (pready),
        .pslverr_o    (pslverr),
        .noc_i        (noc_in),
        .noc_credit_o (noc_credit),
        .noc_o        (noc_out),
        .noc_ack_i    (noc_ack),
        .mem_o        (mem_req),
        .mem_rdata_i  (mem_rdata)
    );

    // ========================================================================
    // memory model and NoC sink
    // ========================================================================

    assign mem_rdata = mem[mem_req.addr[9:2]];      // word index, 256 words

    always @(posedge clk_i) begin
        if (mem_req.we != '0) begin
            mem[mem_req.addr[9:2]] <= mem_req.wdata;
        end
    end

    // a flit leaves only while the send engine owns the memory port
    always @(posedge clk_i) begin
        if (rst_ni && noc_out.tx && noc_ack && dut0.send_grant) begin
            sink_q.push_back(noc_out.data);
        end
    end

    always @(negedge clk_i) begin
        if (ack_random) begin
            ack_rnd = $random(seed);
            noc_ack = ack_rnd[0];
        end else begin
            noc_ack = 1'b1;
        end
    end

    `include "tb_dmni_tasks.svh"

    // ========================================================================
    // test sequence
    // ========================================================================

    initial begin
        seed       = 39396;
        mismatches = 0;
        timeouts   = 0;
        ack_random = 1'b0;
        rx_stalls  = 1'b0;
        rst_ni     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        noc_in     = '0;
        noc_ack    = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_value(i);
        end
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        registers_readback();
        send_two_buffers();
        send_backpressure();
        receive_whole_packet();
        receive_partial();
        send_and_receive();

        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
